// File: logic/exec_types_pkg.sv
package exec_types_pkg;

	typedef logic [31:0] word;
	typedef logic [7:0] shift_amt;
	typedef logic [11:0] imm_field;
	typedef logic [4:0] shift_imm_field;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	// ARM data-processing opcode order
	typedef enum logic [3:0] {
		ALU_AND = 4'h0,
		ALU_EOR = 4'h1,
		ALU_SUB = 4'h2,
		ALU_RSB = 4'h3,
		ALU_ADD = 4'h4,
		ALU_ADC = 4'h5,
		ALU_SBC = 4'h6,
		ALU_RSC = 4'h7,
		ALU_TST = 4'h8,
		ALU_TEQ = 4'h9,
		ALU_CMP = 4'ha,
		ALU_CMN = 4'hb,
		ALU_ORR = 4'hc,
		ALU_MOV = 4'hd,
		ALU_BIC = 4'he,
		ALU_MVN = 4'hf
	} alu_op;

	// LSL is all clear, LSR sets shr, ASR adds sign_extend and ROR adds ror
	typedef struct packed {
		logic shr;
		logic ror;
		logic sign_extend;
	} shifter_control;

	typedef struct packed {
		logic           is_imm;
		imm_field       imm;
		logic           shift_by_reg;
		shift_imm_field shift_imm;
		shifter_control shifter;
	} snd_operand;

	typedef struct packed {
		alu_op      op;
		logic       set_flags;
		snd_operand snd;
	} insn_decode;

	typedef struct packed {
		insn_decode dec;
		word        rd_value_a;
		word        rd_value_b;
		word        rd_value_s;
	} issue_packet;

	typedef struct packed {
		word      q;
		logic     writes_rd;
		psr_flags flags;
	} exec_result;

	function automatic logic is_logical(alu_op op);
		case (op)
			ALU_AND, ALU_EOR, ALU_TST, ALU_TEQ,
			ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// the compare and test group only updates flags
	function automatic logic writes_result(alu_op op);
		return !(op inside {ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN});
	endfunction

endpackage

// File: logic/exec_ctrl_pkg.sv
package exec_ctrl_pkg;

	// one instruction walks these in order, skipping RD_INDIRECT_SHIFT
	// when the shift amount is an immediate
	typedef enum logic [1:0] {
		ISSUE             = 2'd0,
		RD_INDIRECT_SHIFT = 2'd1,
		WITH_SHIFT        = 2'd2,
		EXECUTE           = 2'd3
	} ctrl_cycle;

endpackage

// File: logic/exec_shifter.sv
`timescale 1ns/1ns

module exec_shifter
	import exec_types_pkg::*;
#(
	parameter int data_width = 32
)
(
	input  logic [data_width-1:0] shift_in,
	input  shifter_control        shifter,
	input  shift_amt              shifter_shift,
	input  logic                  c_in,

	output logic [data_width-1:0] q_shifter,
	output logic                  c_shifter
);

	localparam int rot_bits = $clog2(data_width);

	logic [data_width:0]   lsl_ext;
	logic [data_width:0]   lsr_ext;
	logic [data_width:0]   asr_ext;
	logic [data_width-1:0] rot_q;
	logic [rot_bits-1:0]   rot;

	// one spare bit beside the value catches the last bit shifted out,
	// and shifts past the width drain everything to zero or to the sign
	assign lsl_ext = {1'b0, shift_in} << shifter_shift;
	assign lsr_ext = {shift_in, 1'b0} >> shifter_shift;
	assign asr_ext = $signed({shift_in, 1'b0}) >>> shifter_shift;

	// rotation only needs the amount modulo the width
	assign rot = shifter_shift[rot_bits-1:0];
	assign rot_q = (shift_in >> rot) | (shift_in << (data_width - rot));

	always_comb begin
		q_shifter = shift_in;
		c_shifter = c_in;

		if (shifter_shift != '0) begin
			if (!shifter.shr) begin
				{c_shifter, q_shifter} = lsl_ext;
			end else if (shifter.ror) begin
				q_shifter = rot_q;
				c_shifter = rot_q[data_width-1];
			end else if (shifter.sign_extend) begin
				{q_shifter, c_shifter} = asr_ext;
			end else begin
				{q_shifter, c_shifter} = lsr_ext;
			end
		end
	end

endmodule

// File: logic/exec_alu.sv
`timescale 1ns/1ns

module exec_alu
	import exec_types_pkg::*;
#(
	parameter int data_width = 32
)
(
	input  alu_op                 alu,
	input  logic [data_width-1:0] alu_a,
	input  logic [data_width-1:0] alu_b,
	input  logic                  c_in,

	output logic [data_width-1:0] q_alu,
	output psr_flags              alu_flags
);

	logic [data_width-1:0] add_x;
	logic [data_width-1:0] add_y;
	logic                  add_c;
	logic [data_width:0]   sum;

	assign sum = {1'b0, add_x} + {1'b0, add_y} + {{data_width{1'b0}}, add_c};

	// every subtraction becomes x + ~y + carry, so C reads as no borrow
	always_comb begin
		add_x = alu_a;
		add_y = alu_b;
		add_c = 1'b0;
		unique case (alu)
			ALU_SUB, ALU_CMP: begin
				add_y = ~alu_b;
				add_c = 1'b1;
			end
			ALU_RSB: begin
				add_x = alu_b;
				add_y = ~alu_a;
				add_c = 1'b1;
			end
			ALU_ADC:
				add_c = c_in;
			ALU_SBC: begin
				add_y = ~alu_b;
				add_c = c_in;
			end
			ALU_RSC: begin
				add_x = alu_b;
				add_y = ~alu_a;
				add_c = c_in;
			end
			default: ;
		endcase
	end

	always_comb begin
		unique case (alu)
			ALU_AND, ALU_TST: q_alu = alu_a & alu_b;
			ALU_EOR, ALU_TEQ: q_alu = alu_a ^ alu_b;
			ALU_ORR:          q_alu = alu_a | alu_b;
			ALU_MOV:          q_alu = alu_b;
			ALU_BIC:          q_alu = alu_a & ~alu_b;
			ALU_MVN:          q_alu = ~alu_b;
			default:          q_alu = sum[data_width-1:0];
		endcase
	end

	always_comb begin
		alu_flags.n = q_alu[data_width-1];
		alu_flags.z = q_alu == '0;
		if (is_logical(alu)) begin
			alu_flags.c = c_in;
			alu_flags.v = 1'b0;
		end else begin
			alu_flags.c = sum[data_width];
			alu_flags.v = (add_x[data_width-1] == add_y[data_width-1])
				&& (sum[data_width-1] != add_x[data_width-1]);
		end
	end

endmodule

// File: logic/exec_sequencer.sv
`timescale 1ns/1ns

module exec_sequencer
	import exec_types_pkg::*, exec_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        reset,

	input  logic        issue_valid,
	input  issue_packet issue,
	input  logic        result_ready,

	input  word         q_alu,
	input  psr_flags    alu_flags,
	input  logic        c_shifter,
	input  logic        data_snd_shift_by_reg,

	output logic        issue_ready,
	output logic        result_valid,
	output exec_result  result,

	output ctrl_cycle   cycle,
	output ctrl_cycle   next_cycle,
	output insn_decode  dec,
	output word         rd_value_a,
	output word         rd_value_b,
	output word         rd_value_s,
	output psr_flags    flags
);

	issue_packet held;
	issue_packet view;
	psr_flags    new_flags;
	logic        accept;
	logic        retire;

	assign issue_ready = cycle == ISSUE;
	assign result_valid = cycle == EXECUTE;
	assign accept = issue_valid && issue_ready;
	assign retire = result_valid && result_ready;

	// while in ISSUE the operand block looks straight at the port, so its
	// decode latch fills on the same edge that accepts the packet
	assign view = issue_ready ? issue : held;
	assign dec = view.dec;
	assign rd_value_a = view.rd_value_a;
	assign rd_value_b = view.rd_value_b;
	assign rd_value_s = view.rd_value_s;

	always_comb begin
		next_cycle = cycle;
		unique case (cycle)
			ISSUE:
				if (accept)
					next_cycle = issue.dec.snd.shift_by_reg ? RD_INDIRECT_SHIFT : WITH_SHIFT;
			RD_INDIRECT_SHIFT:
				next_cycle = WITH_SHIFT;
			// the register amount has to be read before the shift happens
			WITH_SHIFT:
				next_cycle = data_snd_shift_by_reg ? RD_INDIRECT_SHIFT : EXECUTE;
			EXECUTE:
				if (retire)
					next_cycle = ISSUE;
		endcase
	end

	// logical ops take C from the saved shifter carry, which the shifter
	// passes through untouched during EXECUTE, and leave V alone
	always_comb begin
		new_flags = alu_flags;
		if (is_logical(dec.op)) begin
			new_flags.c = c_shifter;
			new_flags.v = flags.v;
		end
		if (!dec.set_flags)
			new_flags = flags;
	end

	always_comb begin
		result.q = q_alu;
		result.writes_rd = writes_result(dec.op);
		result.flags = new_flags;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cycle <= ISSUE;
			flags <= '0;
		end else begin
			cycle <= next_cycle;
			if (retire)
				flags <= new_flags;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			held <= issue;
	end

endmodule

// File: logic/exec_operand_ctrl.sv
`timescale 1ns/1ns

module exec_operand_ctrl
	import exec_types_pkg::*, exec_ctrl_pkg::*;
(
	input  logic           clk,

	input  insn_decode     dec,
	input  word            rd_value_a,
	input  word            rd_value_b,
	input  word            rd_value_s,
	input  word            q_shifter,
	input  logic           c_shifter,

	input  ctrl_cycle      cycle,
	input  ctrl_cycle      next_cycle,
	input  psr_flags       flags,

	output alu_op          alu,
	output word            alu_a,
	output word            alu_b,
	output word            saved_base,
	output word            shift_in,
	output shifter_control shifter,
	output shift_amt       shifter_shift,
	output logic           c_in,
	output logic           trivial_shift,
	output logic           data_snd_shift_by_reg
);

	logic     data_snd_is_imm;
	imm_field data_imm;
	shift_amt data_shift;

	assign trivial_shift = shifter_shift == '0;
	assign alu_a = rd_value_a;

	always_comb begin
		// a zero amount in EXECUTE makes the shifter hand back c_in as its carry
		unique case (cycle)
			RD_INDIRECT_SHIFT: shifter_shift = rd_value_s[7:0];
			EXECUTE:           shifter_shift = '0;
			default:           shifter_shift = data_shift;
		endcase

		if (cycle == EXECUTE)
			shift_in = saved_base;
		else
			shift_in = rd_value_b;

		if (cycle == EXECUTE)
			alu_b = saved_base;
		else if (data_snd_is_imm)
			alu_b = word'(data_imm);
		else
			alu_b = rd_value_b;
	end

	always_ff @(posedge clk) begin
		unique case (cycle)
			ISSUE:
				if (next_cycle != ISSUE) begin
					alu <= dec.op;
					c_in <= flags.c;

					data_snd_is_imm <= dec.snd.is_imm;
					data_snd_shift_by_reg <= dec.snd.shift_by_reg;
					data_imm <= dec.snd.imm;
					data_shift <= shift_amt'(dec.snd.shift_imm);

					shifter <= dec.snd.shifter;
				end

			RD_INDIRECT_SHIFT: begin
				data_shift <= rd_value_s[7:0];
				data_snd_shift_by_reg <= 1'b0;
			end

			WITH_SHIFT:
				if (data_snd_is_imm) begin
					saved_base <= word'(data_imm);
				end else begin
					saved_base <= q_shifter;
					// arithmetic ops keep the flag carry for ADC, SBC and RSC
					if (is_logical(alu) && !trivial_shift)
						c_in <= c_shifter;
				end

			default: ;
		endcase
	end

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ns

module exec_unit
	import exec_types_pkg::*, exec_ctrl_pkg::*;
#(
	parameter int data_width = 32
)
(
	input  logic        clk,
	input  logic        reset,

	input  logic        issue_valid,
	input  issue_packet issue,
	output logic        issue_ready,

	output logic        result_valid,
	output exec_result  result,
	input  logic        result_ready
);

	ctrl_cycle      cycle;
	ctrl_cycle      next_cycle;
	insn_decode     dec;
	word            rd_value_a;
	word            rd_value_b;
	word            rd_value_s;
	psr_flags       flags;

	alu_op          alu;
	word            alu_a;
	word            alu_b;
	word            shift_in;
	shifter_control shifter;
	shift_amt       shifter_shift;
	logic           c_in;
	logic           data_snd_shift_by_reg;

	word            q_alu;
	psr_flags       alu_flags;
	word            q_shifter;
	logic           c_shifter;

	exec_sequencer i_sequencer (
		.clk                   (clk),
		.reset                 (reset),
		.issue_valid           (issue_valid),
		.issue                 (issue),
		.result_ready          (result_ready),
		.q_alu                 (q_alu),
		.alu_flags             (alu_flags),
		.c_shifter             (c_shifter),
		.data_snd_shift_by_reg (data_snd_shift_by_reg),
		.issue_ready           (issue_ready),
		.result_valid          (result_valid),
		.result                (result),
		.cycle                 (cycle),
		.next_cycle            (next_cycle),
		.dec                   (dec),
		.rd_value_a            (rd_value_a),
		.rd_value_b            (rd_value_b),
		.rd_value_s            (rd_value_s),
		.flags                 (flags)
	);

	// saved_base and trivial_shift are consumed inside the operand block
	exec_operand_ctrl i_operand_ctrl (
		.clk                   (clk),
		.dec                   (dec),
		.rd_value_a            (rd_value_a),
		.rd_value_b            (rd_value_b),
		.rd_value_s            (rd_value_s),
		.q_shifter             (q_shifter),
		.c_shifter             (c_shifter),
		.cycle                 (cycle),
		.next_cycle            (next_cycle),
		.flags                 (flags),
		.alu                   (alu),
		.alu_a                 (alu_a),
		.alu_b                 (alu_b),
		.saved_base            (),
		.shift_in              (shift_in),
		.shifter               (shifter),
		.shifter_shift         (shifter_shift),
		.c_in                  (c_in),
		.trivial_shift         (),
		.data_snd_shift_by_reg (data_snd_shift_by_reg)
	);

	exec_shifter #(
		.data_width (data_width)
	) i_shifter (
		.shift_in      (shift_in),
		.shifter       (shifter),
		.shifter_shift (shifter_shift),
		.c_in          (c_in),
		.q_shifter     (q_shifter),
		.c_shifter     (c_shifter)
	);

	exec_alu #(
		.data_width (data_width)
	) i_alu (
		.alu       (alu),
		.alu_a     (alu_a),
		.alu_b     (alu_b),
		.c_in      (c_in),
		.q_alu     (q_alu),
		.alu_flags (alu_flags)
	);

endmodule

// File: test/exec_unit_props.sv
`timescale 1ns/1ns

module exec_unit_props
	import exec_types_pkg::*, exec_ctrl_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input logic       issue_valid,
	input logic       issue_ready,
	input logic       result_valid,
	input logic       result_ready,
	input exec_result result,
	input insn_decode dec,
	input ctrl_cycle  cycle
);

	// a stalled result stays valid and keeps the instruction behind it
	hold_while_stalled: assert property (
		@(posedge clk) disable iff (reset)
		result_valid && !result_ready |=> result_valid && $stable(result) && $stable(dec)
	) else $error("result port changed while stalled");

	// ISSUE is only reached from an idle ISSUE or from a result that transfers
	issue_only_when_idle: assert property (
		@(posedge clk) disable iff (reset)
		issue_ready |->
			$past(issue_ready && !issue_valid) || $past(result_valid && result_ready)
	) else $error("issue_ready high while an instruction is in flight");

	execute_after_shift: assert property (
		@(posedge clk) disable iff (reset)
		cycle == WITH_SHIFT |=> cycle == EXECUTE
	) else $error("WITH_SHIFT was not followed by EXECUTE");

endmodule

bind exec_sequencer exec_unit_props i_props (
	.clk          (clk),
	.reset        (reset),
	.issue_valid  (issue_valid),
	.issue_ready  (issue_ready),
	.result_valid (result_valid),
	.result_ready (result_ready),
	.result       (result),
	.dec          (dec),
	.cycle        (cycle)
);

// File: test/exec_unit_tb.sv
`timescale 1ns/1ns

module exec_unit_tb
	import exec_types_pkg::*;
();

	localparam int clk_period = 8;
	localparam int op_repeats = 8;
	localparam int carry_packets = 48;
	localparam int stall_packets = 64;
	localparam int total_packets = 16 * op_repeats + 4 * 32 + 4 * 8 * 2
		+ carry_packets + stall_packets;
	// ten cycles covers issue, the longest latency and the longest stall
	localparam int timeout_ns = (total_packets * 10 + 8 + 200) * clk_period;

	logic        clk;
	logic        reset;
	logic        issue_valid;
	issue_packet issue;
	logic        issue_ready;
	logic        result_valid;
	exec_result  result;
	logic        result_ready;
	logic        stall_mode;

	psr_flags    model_flags;
	exec_result  expected_q[$];
	exec_result  expected;
	exec_result  stalled_result;
	logic        stalled;
	logic        awaiting_first;
	int          exp_latency;
	int          accept_cycle;
	int          cycle_count;
	int          accepted = 0;
	int          received = 0;
	int          value_errors = 0;
	int          latency_errors = 0;
	int          protocol_errors = 0;

	alu_op    logical_ops [8] = '{ALU_AND, ALU_EOR, ALU_TST, ALU_TEQ,
		ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN};
	alu_op    carry_ops [8] = '{ALU_ADD, ALU_SUB, ALU_CMP, ALU_CMN,
		ALU_ADC, ALU_SBC, ALU_RSC, ALU_MOV};
	shift_amt reg_amounts [8] = '{8'd0, 8'd1, 8'd31, 8'd32, 8'd33, 8'd64, 8'd200, 8'd255};

	exec_unit #(
		.data_width (32)
	) i_dut (
		.clk          (clk),
		.reset        (reset),
		.issue_valid  (issue_valid),
		.issue        (issue),
		.issue_ready  (issue_ready),
		.result_valid (result_valid),
		.result       (result),
		.result_ready (result_ready)
	);

	always #4 clk = ~clk;

	function automatic shifter_control shift_kind(int k);
		shifter_control sc;

		sc = '0;
		case (k)
			1: sc.shr = 1'b1;
			2: begin
				sc.shr = 1'b1;
				sc.sign_extend = 1'b1;
			end
			3: begin
				sc.shr = 1'b1;
				sc.ror = 1'b1;
			end
			default: ;
		endcase
		return sc;
	endfunction

	// returns {carry, value} after applying the shift rules to v
	function automatic logic [32:0] shift_operand(word v, shifter_control sc, shift_amt n,
		logic c);
		int         k;
		logic [4:0] idx;
		word        rotated;

		k = int'(n);
		if (k == 0)
			return {c, v};
		if (sc.shr && sc.ror) begin
			k = k % 32;
			rotated = (k == 0) ? v : ((v >> k) | (v << (32 - k)));
			return {rotated[31], rotated};
		end
		if (sc.shr && sc.sign_extend) begin
			if (k >= 32)
				return {33{v[31]}};
			idx = 5'(k - 1);
			return {v[idx], word'($signed(v) >>> k)};
		end
		if (k > 32)
			return '0;
		if (!sc.shr) begin
			idx = 5'(32 - k);
			return (k == 32) ? {v[0], 32'd0} : {v[idx], v << k};
		end
		idx = 5'(k - 1);
		return (k == 32) ? {v[31], 32'd0} : {v[idx], v >> k};
	endfunction

	function automatic exec_result predict(issue_packet p, psr_flags cur);
		exec_result  r;
		psr_flags    nf;
		logic [32:0] wide;
		word         b;
		word         x;
		word         y;
		word         q;
		logic        sh_c;
		logic        logical;
		logic        sub;
		logic        extra;

		if (p.dec.snd.is_imm) begin
			b = {20'd0, p.dec.snd.imm};
			sh_c = cur.c;
		end else begin
			{sh_c, b} = shift_operand(p.rd_value_b, p.dec.snd.shifter,
				p.dec.snd.shift_by_reg ? p.rd_value_s[7:0] : {3'd0, p.dec.snd.shift_imm},
				cur.c);
		end
		logical = 1'b1;
		q = '0;
		case (p.dec.op)
			ALU_AND, ALU_TST: q = p.rd_value_a & b;
			ALU_EOR, ALU_TEQ: q = p.rd_value_a ^ b;
			ALU_ORR:          q = p.rd_value_a | b;
			ALU_MOV:          q = b;
			ALU_BIC:          q = p.rd_value_a & ~b;
			ALU_MVN:          q = ~b;
			default:          logical = 1'b0;
		endcase
		nf = cur;
		if (logical) begin
			nf.c = sh_c;
		end else begin
			// extra is the carry in for adds and the borrow for subtracts
			x = p.rd_value_a;
			y = b;
			sub = !(p.dec.op inside {ALU_ADD, ALU_ADC, ALU_CMN});
			extra = (p.dec.op inside {ALU_ADC, ALU_SBC, ALU_RSC}) ? (sub ? !cur.c : cur.c) : 1'b0;
			if (p.dec.op inside {ALU_RSB, ALU_RSC}) begin
				x = b;
				y = p.rd_value_a;
			end
			if (sub) begin
				wide = {1'b0, x} - {1'b0, y} - {32'd0, extra};
				nf.c = !wide[32];
				nf.v = (x[31] != y[31]) && (wide[31] != x[31]);
			end else begin
				wide = {1'b0, x} + {1'b0, y} + {32'd0, extra};
				nf.c = wide[32];
				nf.v = (x[31] == y[31]) && (wide[31] != x[31]);
			end
			q = wide[31:0];
		end
		nf.n = q[31];
		nf.z = q == '0;
		r.q = q;
		// opcodes 8 to 11 are the compare and test group
		r.writes_rd = p.dec.op[3:2] != 2'b10;
		r.flags = p.dec.set_flags ? nf : cur;
		return r;
	endfunction

	task automatic check_result(string what, exec_result got, exec_result exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t: %s: got q=%h wr=%b nzcv=%b, expected q=%h wr=%b nzcv=%b",
				$time, what, got.q, got.writes_rd, got.flags, exp.q, exp.writes_rd, exp.flags);
		end
	endtask

	task automatic check_latency(int got, int exp);
		if (got != exp) begin
			latency_errors++;
			$display("[ERROR] %0t: result valid %0d cycles after issue, expected %0d",
				$time, got, exp);
		end
	endtask

	function automatic word corner_word();
		case ($urandom % 8)
			0: return 32'h0000_0000;
			1: return 32'h7fff_ffff;
			2: return 32'h8000_0000;
			3: return 32'hffff_ffff;
			default: return $urandom;
		endcase
	endfunction

	function automatic issue_packet random_packet();
		issue_packet p;

		p.dec.op = alu_op'(4'($urandom));
		p.dec.set_flags = 1'($urandom);
		p.dec.snd.is_imm = 1'($urandom);
		p.dec.snd.imm = 12'($urandom);
		p.dec.snd.shift_by_reg = !p.dec.snd.is_imm && ($urandom % 2 == 0);
		p.dec.snd.shift_imm = 5'($urandom);
		p.dec.snd.shifter = shift_kind($urandom % 4);
		p.rd_value_a = $urandom;
		p.rd_value_b = $urandom;
		p.rd_value_s = $urandom;
		if ($urandom % 4 != 0)
			p.rd_value_s[7:0] = 8'($urandom % 40);
		return p;
	endfunction

	function automatic issue_packet junk_packet();
		logic [127:0] bits;

		bits = {$urandom, $urandom, $urandom, $urandom};
		return bits[$bits(issue_packet)-1:0];
	endfunction

	// entered and left 1 ns after a rising edge
	task automatic send_packet(issue_packet p);
		issue_valid = 1'b1;
		issue = p;
		@(posedge clk);
		while (!issue_ready)
			@(posedge clk);
		#1;
		issue_valid = 1'b0;
		issue = junk_packet();
	endtask

	task automatic idle_cycles(int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic sweep_opcodes();
		issue_packet p;

		for (int op = 0; op < 16; op++) begin
			for (int i = 0; i < op_repeats; i++) begin
				p = random_packet();
				p.dec.op = alu_op'(4'(op));
				p.dec.snd.is_imm = 1'b1;
				p.dec.snd.shift_by_reg = 1'b0;
				p.rd_value_a = corner_word();
				send_packet(p);
				idle_cycles($urandom % 3);
			end
		end
	endtask

	task automatic walk_immediate_shifts();
		issue_packet p;

		for (int kind = 0; kind < 4; kind++) begin
			for (int amt = 0; amt < 32; amt++) begin
				p = random_packet();
				p.dec.op = logical_ops[3'($urandom)];
				p.dec.set_flags = 1'b1;
				p.dec.snd.is_imm = 1'b0;
				p.dec.snd.shift_by_reg = 1'b0;
				p.dec.snd.shift_imm = 5'(amt);
				p.dec.snd.shifter = shift_kind(kind);
				send_packet(p);
			end
		end
	endtask

	// each register shift is followed by an immediate op to mix both latencies
	task automatic mix_register_shifts();
		issue_packet p;

		for (int kind = 0; kind < 4; kind++) begin
			for (int i = 0; i < 8; i++) begin
				p = random_packet();
				p.dec.op = logical_ops[3'($urandom)];
				p.dec.set_flags = 1'b1;
				p.dec.snd.is_imm = 1'b0;
				p.dec.snd.shift_by_reg = 1'b1;
				p.dec.snd.shifter = shift_kind(kind);
				p.rd_value_s[7:0] = reg_amounts[3'(i)];
				send_packet(p);
				p = random_packet();
				p.dec.snd.is_imm = 1'b1;
				p.dec.snd.shift_by_reg = 1'b0;
				send_packet(p);
			end
		end
	endtask

	task automatic chain_carry_ops();
		issue_packet p;

		for (int i = 0; i < carry_packets; i++) begin
			p = random_packet();
			p.dec.op = carry_ops[3'($urandom)];
			p.dec.set_flags = $urandom % 3 != 0;
			p.rd_value_a = corner_word();
			p.rd_value_b = corner_word();
			send_packet(p);
		end
	endtask

	task automatic stall_random_traffic();
		stall_mode = 1'b1;
		for (int i = 0; i < stall_packets; i++)
			send_packet(random_packet());
		stall_mode = 1'b0;
	endtask

	// expected values are predicted on the accepting edge, since only one
	// instruction is in flight and the flags are settled by then
	always @(posedge clk) begin
		if (reset) begin
			model_flags = '0;
			stalled = 1'b0;
			awaiting_first = 1'b0;
			cycle_count = 0;
		end else begin
			if (result_valid) begin
				if (issue_ready) begin
					protocol_errors++;
					$display("[ERROR] %0t: issue_ready high while a result is waiting", $time);
				end
				if (awaiting_first) begin
					check_latency(cycle_count - accept_cycle, exp_latency);
					awaiting_first = 1'b0;
				end
				if (stalled)
					check_result("result changed while stalled", result, stalled_result);
				if (result_ready) begin
					stalled = 1'b0;
					if (expected_q.size() == 0) begin
						protocol_errors++;
						$display("A result came back with no instruction issued at %0t", $time);
					end else begin
						check_result("result", result, expected_q.pop_front());
						received++;
					end
				end else begin
					stalled = 1'b1;
					stalled_result = result;
				end
			end
			if (issue_valid && issue_ready) begin
				expected = predict(issue, model_flags);
				model_flags = expected.flags;
				expected_q.push_back(expected);
				exp_latency = issue.dec.snd.shift_by_reg ? 3 : 2;
				accept_cycle = cycle_count;
				awaiting_first = 1'b1;
				accepted++;
			end
			cycle_count++;
		end
	end

	initial begin : ready_driver
		int stall_left;

		stall_left = 0;
		@(negedge reset);
		forever begin
			@(posedge clk);
			#1;
			if (stall_left > 0) begin
				result_ready = 1'b0;
				stall_left--;
			end else if (stall_mode && $urandom % 3 == 0) begin
				result_ready = 1'b0;
				stall_left = int'($urandom % 5);
			end else begin
				result_ready = 1'b1;
			end
		end
	end

	initial begin
		#(timeout_ns);
		$display("Timeout: the run did not finish within %0d ns", timeout_ns);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue = '0;
		result_ready = 1'b1;
		stall_mode = 1'b0;
		void'($urandom(32'ha1b61b57));
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		sweep_opcodes();
		walk_immediate_shifts();
		mix_register_shifts();
		chain_carry_ops();
		stall_random_traffic();

		while (received != accepted) begin
			@(posedge clk);
			#1;
		end
		idle_cycles(4);
		if (accepted != total_packets || expected_q.size() != 0) begin
			protocol_errors++;
			$display("Instructions went missing: %0d sent, %0d accepted, %0d results",
				total_packets, accepted, received);
		end

		$display("Errors: %0d result, %0d latency, %0d protocol over %0d results",
			value_errors, latency_errors, protocol_errors, received);
		if (value_errors + latency_errors + protocol_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: verilog.f
logic/exec_types_pkg.sv
logic/exec_ctrl_pkg.sv
logic/exec_shifter.sv
logic/exec_alu.sv
logic/exec_sequencer.sv
logic/exec_operand_ctrl.sv
logic/exec_unit.sv
test/exec_unit_props.sv
test/exec_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compiles the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f verilog.f --top-module exec_unit_tb -o exec_unit_sim \
	&& ./obj_dir/exec_unit_sim | tee /dev/stderr | grep -q "All tests passed" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
